// File: compile.f
source/uart_pkg.sv
source/uart_baud.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_ctrl.sv
source/uart_top.sv
verif/tb_uart.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it, and judge the result from sim.log

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_uart -f compile.f -o tb_uart \
	> build.log 2>&1 &&
./obj_dir/tb_uart > sim.log 2>&1 ||
{ echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "TESTBENCH PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }

// File: verif/tb_uart.sv
/* UART testbench
   Register bus and serial line stimulus against a behavioral model of the port */
module tb_uart
	import uart_pkg::*;
();

	localparam int BIT_CYCLES   = 64;
	localparam int FRAMES       = 14;
	// Start, 8 data, parity and stop at divisor 3
	localparam int FRAME_CYCLES = 11 * BIT_CYCLES;
	// Twice the serial time covers bus polling and idle gaps
	localparam int MAX_CYCLES   = 2 * FRAMES * FRAME_CYCLES;

	localparam logic [15:0] PAR_ON   = 16'd1 << CTRL_PAREN;
	localparam logic [15:0] EVEN_SEL = 16'd1 << CTRL_EVEN;
	localparam logic [15:0] RXPOL_ON = 16'd1 << CTRL_RXPOL;
	localparam logic [15:0] CLR_ERR  = 16'd1 << CTRL_CLRERR;

	logic        sys_clk;
	logic        resetl;
	logic [1:0]  addr;
	logic [15:0] wdata;
	logic        wr;
	logic        rd;
	logic [15:0] rdata;
	logic        serin;
	logic        serout;
	logic        error;

	int          seed;
	int          rnd;
	int          cycles;
	int          checks;
	int          errors;
	int          test_errs;
	logic        inv;
	logic        cur_paren;
	logic        cur_even;
	// Model of the status register and the held receive byte
	logic [15:0] exp_stat;
	logic [7:0]  exp_data;
	logic [7:0]  b0;
	logic [7:0]  b1;
	// Frames decoded from serout, {stop, parity, data}
	logic [9:0]  tx_q[$];

	uart_top #(
		.DIV_WIDTH(16)
	) UUT (
		.sys_clk(sys_clk),
		.resetl (resetl),
		.addr   (addr),
		.wdata  (wdata),
		.wr     (wr),
		.rd     (rd),
		.rdata  (rdata),
		.serin  (serin),
		.serout (serout),
		.error  (error)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Parity bit a correct transmitter puts on the line
	function automatic logic parity_bit(input logic [7:0] data, input logic even_sel);
		return even_sel ? ^data : ~^data;
	endfunction

	// Status and held byte after one frame, from the flag rules of the port
	function automatic logic [23:0] rx_expect(input logic [7:0] data, input logic par_en,
			input logic even_sel, input logic par_bit, input logic stop_bit,
			input logic [15:0] stat, input logic [7:0] held);
		logic [15:0] s;
		logic [7:0]  d;
		s = stat;
		d = held;
		// Pending error blocks new start bits
		if (!(stat[STAT_PE] | stat[STAT_OE] | stat[STAT_FE])) begin
			if (data == 8'h00 && !stop_bit && !(par_en && par_bit)) begin
				s[STAT_BRK] = 1'b1;
			end else if (stat[STAT_RBF]) begin
				// Byte lost, buffer keeps the old one
				s[STAT_OE] = 1'b1;
			end else begin
				s[STAT_RBF] = 1'b1;
				s[STAT_PE]  = par_en && (par_bit != parity_bit(data, even_sel));
				s[STAT_FE]  = !stop_bit;
				d = data;
			end
		end
		return {s, d};
	endfunction

	task automatic check_value(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			errors++;
			test_errs++;
		end
	endtask

	task automatic bus_write(input uart_reg_e a, input logic [15:0] d);
		@(posedge sys_clk);
		addr  <= a;
		wdata <= d;
		wr    <= 1'b1;
		@(posedge sys_clk);
		wr    <= 1'b0;
	endtask

	task automatic bus_read(input uart_reg_e a, output logic [15:0] d);
		@(posedge sys_clk);
		addr <= a;
		rd   <= 1'b1;
		// Mid-cycle sample of the combinational read mux
		@(negedge sys_clk);
		d = rdata;
		@(posedge sys_clk);
		rd <= 1'b0;
	endtask

	// Idle level follows rxpol so the receiver never sees a false start
	task automatic set_ctrl(input logic [15:0] val);
		bus_write(UART_CTRL, val);
		cur_paren = val[CTRL_PAREN];
		cur_even  = val[CTRL_EVEN];
		inv       = val[CTRL_RXPOL];
		serin    <= ~val[CTRL_RXPOL];
		if (val[CTRL_CLRERR]) begin
			exp_stat[STAT_PE] = 1'b0;
			exp_stat[STAT_OE] = 1'b0;
			exp_stat[STAT_FE] = 1'b0;
		end
	endtask

	task automatic drive_bit(input logic v, input int n);
		serin <= v ^ inv;
		repeat (n) @(posedge sys_clk);
	endtask

	task automatic send_frame(input logic [7:0] data, input logic par_bit,
			input logic stop_bit, input logic to_idle);
		int k;
		{exp_stat, exp_data} = rx_expect(data, cur_paren, cur_even, par_bit, stop_bit,
			exp_stat, exp_data);
		@(posedge sys_clk);
		drive_bit(1'b0, BIT_CYCLES);
		for (k = 0; k < 8; k++) begin
			drive_bit(data[k], BIT_CYCLES);
		end
		if (cur_paren) begin
			drive_bit(par_bit, BIT_CYCLES);
		end
		// Stop level held past its sample point
		drive_bit(stop_bit, 48);
		if (to_idle) begin
			drive_bit(1'b1, BIT_CYCLES - 48);
		end
	endtask

	task automatic wait_status(input int b, input logic val);
		logic [15:0] v;
		int          n;
		n = 0;
		bus_read(UART_STAT, v);
		while (v[b] !== val && n < 500) begin
			bus_read(UART_STAT, v);
			n++;
		end
		if (v[b] !== val) begin
			$display("Status bit %0d never reached %0b", b, val);
			errors++;
			test_errs++;
		end
	endtask

	task automatic verify_status();
		logic [15:0] v;
		bus_read(UART_STAT, v);
		check_value("status", v, exp_stat);
		@(negedge sys_clk);
		check_value("error", {15'd0, error},
			{15'd0, exp_stat[STAT_PE] | exp_stat[STAT_OE] | exp_stat[STAT_FE]});
	endtask

	task automatic read_rx_data();
		logic [15:0] v;
		bus_read(UART_DATA, v);
		check_value("rx_data", v, {8'h00, exp_data});
		exp_stat[STAT_RBF] = 1'b0;
	endtask

	task automatic receive_byte(input logic [7:0] data, input logic par_bit);
		send_frame(data, par_bit, 1'b1, 1'b1);
		wait_status(STAT_RBF, 1'b1);
		verify_status();
		read_rx_data();
		verify_status();
	endtask

	task automatic verify_tx_frame(input logic [7:0] data);
		logic [9:0] got;
		wait_status(STAT_TXBUSY, 1'b0);
		if (tx_q.size() != 1) begin
			$display("Expected one frame on serout, monitor decoded %0d", tx_q.size());
			errors++;
			test_errs++;
		end else begin
			got = tx_q.pop_front();
			check_value("serout_frame", {6'd0, got},
				{6'd0, 1'b1, parity_bit(data, cur_even), data});
		end
		tx_q.delete();
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// Samples serout at bit centers on the falling edge
	initial begin : serout_monitor
		logic [9:0] frame;
		int         k;
		forever begin
			@(negedge sys_clk);
			if (serout === 1'b0) begin
				frame = '0;
				repeat (BIT_CYCLES / 2) @(negedge sys_clk);
				for (k = 0; k < 8; k++) begin
					repeat (BIT_CYCLES) @(negedge sys_clk);
					frame[k] = serout;
				end
				if (cur_paren) begin
					repeat (BIT_CYCLES) @(negedge sys_clk);
					frame[8] = serout;
				end
				repeat (BIT_CYCLES) @(negedge sys_clk);
				frame[9] = serout;
				tx_q.push_back(frame);
			end
		end
	end

	initial begin
		seed      = 21;
		cycles    = 0;
		checks    = 0;
		errors    = 0;
		test_errs = 0;
		resetl    = 1'b0;
		addr      = 2'd0;
		wdata     = 16'h0000;
		wr        = 1'b0;
		rd        = 1'b0;
		serin     = 1'b1;
		inv       = 1'b0;
		cur_paren = 1'b0;
		cur_even  = 1'b0;
		exp_stat  = 16'h0000;
		exp_data  = 8'h00;
		repeat (3) @(posedge sys_clk);
		resetl <= 1'b1;
		bus_write(UART_DIV, 16'd3);

		verify_status();
		repeat (2) begin
			rnd = $random(seed);
			receive_byte(rnd[7:0], 1'b0);
		end
		end_test("rx random bytes");

		set_ctrl(PAR_ON | EVEN_SEL);
		receive_byte(8'h5C, parity_bit(8'h5C, 1'b1));
		set_ctrl(PAR_ON);
		receive_byte(8'hA7, parity_bit(8'hA7, 1'b0));
		// Flipped parity bit
		receive_byte(8'h3E, ~parity_bit(8'h3E, 1'b0));
		set_ctrl(CLR_ERR);
		verify_status();
		end_test("rx parity");

		rnd = $random(seed);
		b0  = rnd[7:0];
		rnd = $random(seed);
		b1  = rnd[7:0];
		send_frame(b0, 1'b0, 1'b1, 1'b1);
		wait_status(STAT_RBF, 1'b1);
		send_frame(b1, 1'b0, 1'b1, 1'b1);
		wait_status(STAT_OE, 1'b1);
		verify_status();
		read_rx_data();
		// Receiver held off by the overrun, buffer stays empty
		send_frame(~b0, 1'b0, 1'b1, 1'b1);
		verify_status();
		set_ctrl(CLR_ERR);
		verify_status();
		end_test("rx overrun");

		send_frame(8'hA5, 1'b0, 1'b0, 1'b1);
		wait_status(STAT_RBF, 1'b1);
		verify_status();
		read_rx_data();
		set_ctrl(CLR_ERR);
		// All-zero frame, line left at space
		send_frame(8'h00, 1'b0, 1'b0, 1'b0);
		wait_status(STAT_BRK, 1'b1);
		verify_status();
		@(posedge sys_clk);
		serin <= ~inv;
		wait_status(STAT_BRK, 1'b0);
		exp_stat[STAT_BRK] = 1'b0;
		verify_status();
		end_test("rx framing and break");

		set_ctrl(RXPOL_ON);
		repeat (2) begin
			rnd = $random(seed);
			receive_byte(rnd[7:0], 1'b0);
		end
		set_ctrl(16'h0000);
		end_test("rx inverted polarity");

		set_ctrl(PAR_ON | EVEN_SEL);
		rnd = $random(seed);
		b0  = rnd[7:0];
		bus_write(UART_DATA, {8'h00, b0});
		exp_stat[STAT_TXBUSY] = 1'b1;
		verify_status();
		// Second byte lands while the first is on the line
		bus_write(UART_DATA, {8'h00, ~b0});
		exp_stat[STAT_TXBUSY] = 1'b0;
		verify_tx_frame(b0);
		verify_status();
		set_ctrl(PAR_ON);
		rnd = $random(seed);
		b1  = rnd[7:0];
		bus_write(UART_DATA, {8'h00, b1});
		verify_tx_frame(b1);
		verify_status();
		check_value("serout", {15'd0, serout}, 16'h0001);
		end_test("tx frames");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: source/uart_top.sv
/* UART top level
   Register block, baud divider, receiver and transmitter */
module uart_top
	import uart_pkg::*;
#(
	parameter int DIV_WIDTH = 16
) (
	input  logic        sys_clk,
	input  logic        resetl,
	input  logic [1:0]  addr,
	input  logic [15:0] wdata,
	input  logic        wr,
	input  logic        rd,
	output logic [15:0] rdata,
	input  logic        serin,
	output logic        serout,
	output logic        error
);

	logic [DIV_WIDTH-1:0] divisor;
	logic                 tick16;
	logic                 paren;
	logic                 even;
	logic                 rxpol;
	logic                 tx_load;
	logic [7:0]           tx_byte;
	logic                 tx_busy;
	logic                 rx_hold;
	logic                 rx_done;
	logic [7:0]           rx_byte;
	logic                 par_bad;
	logic                 stop_bad;
	logic                 brk;

	uart_ctrl #(
		.DIV_WIDTH(DIV_WIDTH)
	) u_ctrl (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.addr    (uart_reg_e'(addr)),
		.wdata   (wdata),
		.wr      (wr),
		.rd      (rd),
		.rdata   (rdata),
		.divisor (divisor),
		.paren   (paren),
		.even    (even),
		.rxpol   (rxpol),
		.tx_load (tx_load),
		.tx_byte (tx_byte),
		.tx_busy (tx_busy),
		.rx_done (rx_done),
		.rx_byte (rx_byte),
		.par_bad (par_bad),
		.stop_bad(stop_bad),
		.brk     (brk),
		.rx_hold (rx_hold),
		.error   (error)
	);

	uart_baud #(
		.DIV_WIDTH(DIV_WIDTH)
	) u_baud (
		.sys_clk(sys_clk),
		.resetl (resetl),
		.divisor(divisor),
		.tick16 (tick16)
	);

	uart_rx u_rx (
		.sys_clk (sys_clk),
		.resetl  (resetl),
		.tick16  (tick16),
		.serin   (serin),
		.rxpol   (rxpol),
		.paren   (paren),
		.even    (even),
		.rx_hold (rx_hold),
		.rx_done (rx_done),
		.rx_byte (rx_byte),
		.par_bad (par_bad),
		.stop_bad(stop_bad),
		.brk     (brk)
	);

	uart_tx u_tx (
		.sys_clk(sys_clk),
		.resetl (resetl),
		.tick16 (tick16),
		.tx_load(tx_load),
		.tx_byte(tx_byte),
		.paren  (paren),
		.even   (even),
		.serout (serout),
		.tx_busy(tx_busy)
	);

endmodule

// File: source/uart_ctrl.sv
/* UART register block
   Bus decode, config registers, receive buffer, sticky status and read mux */
module uart_ctrl
	import uart_pkg::*;
#(
	parameter int DIV_WIDTH = 16
) (
	input  logic                 sys_clk,
	input  logic                 resetl,
	input  uart_reg_e            addr,
	input  logic [15:0]          wdata,
	input  logic                 wr,
	input  logic                 rd,
	output logic [15:0]          rdata,
	output logic [DIV_WIDTH-1:0] divisor,
	output logic                 paren,
	output logic                 even,
	output logic                 rxpol,
	output logic                 tx_load,
	output logic [7:0]           tx_byte,
	input  logic                 tx_busy,
	input  logic                 rx_done,
	input  logic [7:0]           rx_byte,
	input  logic                 par_bad,
	input  logic                 stop_bad,
	input  logic                 brk,
	output logic                 rx_hold,
	output logic                 error
);

	logic [7:0] rdr;
	logic       rbf;
	logic       pe;
	logic       oe;
	logic       fe;
	logic       data_rd;
	logic       clr_err;
	logic       accept;

	assign data_rd = rd && (addr == UART_DATA);
	assign clr_err = wr && (addr == UART_CTRL) && wdata[CTRL_CLRERR];
	// Busy transmitter drops the write
	assign tx_load = wr && (addr == UART_DATA) && !tx_busy;
	assign tx_byte = wdata[7:0];
	// New byte only taken into an empty buffer
	assign accept  = rx_done && !rbf;

	// Configuration registers
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			paren   <= 1'b0;
			even    <= 1'b0;
			rxpol   <= 1'b0;
			divisor <= '0;
		end else if (wr) begin
			if (addr == UART_CTRL) begin
				paren <= wdata[CTRL_PAREN];
				even  <= wdata[CTRL_EVEN];
				rxpol <= wdata[CTRL_RXPOL];
			end
			if (addr == UART_DIV) begin
				divisor <= wdata[DIV_WIDTH-1:0];
			end
		end
	end

	// Status flags, set by the receiver beats a clear in the same cycle
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			rbf <= 1'b0;
			pe  <= 1'b0;
			oe  <= 1'b0;
			fe  <= 1'b0;
		end else begin
			if (accept) begin
				rbf <= 1'b1;
			end else if (data_rd) begin
				rbf <= 1'b0;
			end
			if (clr_err) begin
				pe <= 1'b0;
				oe <= 1'b0;
				fe <= 1'b0;
			end
			if (accept) begin
				pe <= pe | par_bad;
				fe <= fe | stop_bad;
			end
			if (rx_done && rbf) begin
				oe <= 1'b1;
			end
		end
	end

	// Receive data register
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			rdr <= rx_byte;
		end
	end

	assign error   = pe | oe | fe;
	assign rx_hold = error;

	always_comb begin
		rdata = 16'h0000;
		case (addr)
			UART_DATA: rdata[7:0] = rdr;
			UART_CTRL: begin
				rdata[CTRL_PAREN] = paren;
				rdata[CTRL_EVEN]  = even;
				rdata[CTRL_RXPOL] = rxpol;
			end
			UART_STAT: begin
				rdata[STAT_RBF]    = rbf;
				rdata[STAT_PE]     = pe;
				rdata[STAT_OE]     = oe;
				rdata[STAT_FE]     = fe;
				rdata[STAT_BRK]    = brk;
				rdata[STAT_TXBUSY] = tx_busy;
			end
			UART_DIV:  rdata[DIV_WIDTH-1:0] = divisor;
		endcase
	end

endmodule

// File: source/uart_tx.sv
/* UART transmitter
   Sends start, 8 data bits LSB first, optional parity and one stop bit */
module uart_tx
	import uart_pkg::*;
(
	input  logic       sys_clk,
	input  logic       resetl,
	input  logic       tick16,
	input  logic       tx_load,
	input  logic [7:0] tx_byte,
	input  logic       paren,
	input  logic       even,
	output logic       serout,
	output logic       tx_busy
);

	tx_state_e  state;
	logic [7:0] sr;
	logic [3:0] tick_cnt;
	logic [3:0] bit_cnt;
	logic       par;
	logic       bit_end;

	// 16 ticks per bit
	assign bit_end = tick16 && (tick_cnt == 4'd15);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state    <= TX_IDLE;
			tick_cnt <= 4'd0;
			bit_cnt  <= 4'd0;
		end else begin
			if (tick16) begin
				tick_cnt <= tick_cnt + 4'd1;
			end
			case (state)
				TX_IDLE: begin
					tick_cnt <= 4'd0;
					bit_cnt  <= 4'd0;
					if (tx_load) begin
						state <= TX_START;
					end
				end
				TX_START: if (bit_end) state <= TX_SHIFT;
				TX_SHIFT: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 4'd1;
						// Parity slot is bit 8 when enabled
						if (bit_cnt == (paren ? 4'd8 : 4'd7)) begin
							state <= TX_STOP;
						end
					end
				end
				TX_STOP: if (bit_end) state <= TX_IDLE;
			endcase
		end
	end

	// Data shifter, parity accumulates as bits go out
	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && tx_load) begin
			sr  <= tx_byte;
			par <= ~even;
		end else if (state == TX_SHIFT && bit_end && bit_cnt < 4'd8) begin
			sr  <= {1'b0, sr[7:1]};
			par <= par ^ sr[0];
		end
	end

	always_comb begin
		case (state)
			TX_START: serout = 1'b0;
			TX_SHIFT: serout = bit_cnt[3] ? par : sr[0];
			default:  serout = 1'b1;
		endcase
	end

	assign tx_busy = (state != TX_IDLE);

endmodule

// File: source/uart_rx.sv
/* UART receiver
   16x oversampled 8-bit framer with optional parity, stop check and break detect */
module uart_rx
	import uart_pkg::*;
(
	input  logic       sys_clk,
	input  logic       resetl,
	input  logic       tick16,
	input  logic       serin,
	input  logic       rxpol,
	input  logic       paren,
	input  logic       even,
	input  logic       rx_hold,
	output logic       rx_done,
	output logic [7:0] rx_byte,
	output logic       par_bad,
	output logic       stop_bad,
	output logic       brk
);

	logic [1:0] line_sync;
	logic       line;
	rx_state_e  state;
	logic [3:0] tick_cnt;
	logic [3:0] bit_cnt;
	logic [9:0] sr;
	logic [9:0] sr_nxt;
	logic       sample;
	logic       last_bit;
	logic [7:0] data_w;
	logic       par_w;
	logic       stop_w;
	logic       all_zero;

	// Polarity correction ahead of the two-flop synchronizer
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			line_sync <= 2'b11;
		end else begin
			line_sync <= {line_sync[0], serin ^ rxpol};
		end
	end
	assign line = line_sync[1];

	// Mid-bit sample point while shifting
	assign sample = (state == RX_SHIFT) && tick16 && (tick_cnt == 4'd15);
	// Bit 8 is the stop without parity, bit 9 with it
	assign last_bit = (bit_cnt == {3'b100, paren});
	assign sr_nxt = {line, sr[9:1]};

	// Frame fields as seen at the stop sample
	assign data_w   = paren ? sr_nxt[7:0] : sr_nxt[8:1];
	assign par_w    = sr_nxt[8];
	assign stop_w   = sr_nxt[9];
	assign all_zero = (data_w == 8'h00) && !stop_w && !(paren && par_w);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state    <= RX_IDLE;
			tick_cnt <= 4'd0;
			bit_cnt  <= 4'd0;
			rx_done  <= 1'b0;
			brk      <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			case (state)
				RX_IDLE: begin
					tick_cnt <= 4'd0;
					bit_cnt  <= 4'd0;
					// No new frames while an error is pending
					if (!line && !rx_hold) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (tick16) begin
						if (tick_cnt == 4'd7) begin
							tick_cnt <= 4'd0;
							// Glitch rejection at start bit middle
							if (line) begin
								state <= RX_IDLE;
							end else begin
								state <= RX_SHIFT;
							end
						end else begin
							tick_cnt <= tick_cnt + 4'd1;
						end
					end
				end
				RX_SHIFT: begin
					if (tick16) begin
						tick_cnt <= tick_cnt + 4'd1;
					end
					if (sample) begin
						bit_cnt <= bit_cnt + 4'd1;
						if (last_bit && all_zero) begin
							state <= RX_BREAK;
							brk   <= 1'b1;
						end else if (last_bit) begin
							state   <= RX_IDLE;
							rx_done <= 1'b1;
						end
					end
				end
				RX_BREAK: begin
					// Hold break until line goes back to mark
					if (line) begin
						state <= RX_IDLE;
						brk   <= 1'b0;
					end
				end
			endcase
		end
	end

	// Shift register and result latch
	always_ff @(posedge sys_clk) begin
		if (sample) begin
			sr <= sr_nxt;
			if (last_bit) begin
				rx_byte  <= data_w;
				par_bad  <= paren & (^data_w ^ par_w ^ ~even);
				stop_bad <= ~stop_w;
			end
		end
	end

endmodule

// File: source/uart_baud.sv
/* UART baud divider
   Down counter giving one 16x oversampling tick every divisor+1 clocks */
module uart_baud #(
	parameter int DIV_WIDTH = 16
) (
	input  logic                 sys_clk,
	input  logic                 resetl,
	input  logic [DIV_WIDTH-1:0] divisor,
	output logic                 tick16
);

	logic [DIV_WIDTH-1:0] cnt;
	logic                 cnt_zero;

	assign cnt_zero = (cnt == '0);

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cnt    <= '0;
			tick16 <= 1'b0;
		end else begin
			// Reload on terminal count, pulse the tick
			if (cnt_zero) begin
				cnt <= divisor;
			end else begin
				cnt <= cnt - 1'b1;
			end
			tick16 <= cnt_zero;
		end
	end

endmodule

// File: source/uart_pkg.sv
/* UART shared definitions
   Register map, FSM state encodings and control/status bit positions */
package uart_pkg;

	// Register bus addresses
	typedef enum logic [1:0] {
		UART_DATA = 2'd0,
		UART_CTRL = 2'd1,
		UART_STAT = 2'd2,
		UART_DIV  = 2'd3
	} uart_reg_e;

	// Receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_SHIFT,
		RX_BREAK
	} rx_state_e;

	// Transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_SHIFT,
		TX_STOP
	} tx_state_e;

	// Control word bits
	localparam int CTRL_PAREN  = 0;
	localparam int CTRL_EVEN   = 1;
	localparam int CTRL_RXPOL  = 2;
	localparam int CTRL_CLRERR = 3;

	// Status word bits
	localparam int STAT_RBF    = 0;
	localparam int STAT_PE     = 1;
	localparam int STAT_OE     = 2;
	localparam int STAT_FE     = 3;
	localparam int STAT_BRK    = 4;
	localparam int STAT_TXBUSY = 5;

endpackage
